//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rv_alu_pipe_tb
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/rv_alu_pipe.sv
dv/rv_alu_pipe_tb.sv

//--- dv/rv_alu_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu_pipe_tb import rv_isa_pkg::*, pipe_pkg::*; ();

    localparam int NUM_RANDOM = 300;
    localparam int WAIT_LIMIT = 200;  // Cycles allowed for any single wait

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  instr_valid_i;
    logic [XLEN-1:0]       instr_data_i;
    logic                  instr_ready_o;
    logic                  result_ready_i;
    logic                  result_valid_o;
    logic [REG_ADDR_W-1:0] result_rd_o;
    logic [XLEN-1:0]       result_data_o;
    logic                  result_illegal_o;

    int   seed;
    logic rand_ready;        // Random back-pressure when set
    logic ready_pat [1024];
    int   ready_idx;

    // Reference register file and expected results in issue order
    logic [XLEN-1:0]       mregs [NUM_REGS];
    logic [REG_ADDR_W-1:0] exp_rd_q [$];
    logic [XLEN-1:0]       exp_data_q [$];
    logic                  exp_ill_q [$];
    int                    stamp_q [$];  // Advance count at acceptance
    int                    adv_cnt;
    logic                  stall_prev;
    logic [REG_ADDR_W-1:0] last_rd;
    logic [XLEN-1:0]       last_data;
    logic                  last_ill;

    rv_alu_pipe u_rv_alu_pipe (.*);

    always #5 clk_i = ~clk_i;

    task automatic end_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("mismatch at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
        end_with_failure();
    endtask

    task automatic report_error(input string what);
        $display("error at %0t ns: %s", $time, what);
        end_with_failure();
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // RV32I semantics of one funct3 group
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_SR:   return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_accept(input logic [31:0] word);
        rv_instr_t   ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        alt;
        logic        legal;
        ins   = word;
        a     = mregs[ins.r.rs1];
        b     = mregs[ins.r.rs2];
        alt   = (ins.r.funct7 == F7_ALT);
        legal = 1'b0;
        res   = '0;
        case (ins.r.opcode)
            OPC_OP: begin
                legal = (ins.r.funct7 == F7_BASE) ||
                        (alt && (ins.r.funct3 == F3_ADD || ins.r.funct3 == F3_SR));
                res   = alu_ref(ins.r.funct3, alt, a, b);
            end
            OPC_OP_IMM: begin
                b = {{20{ins.i.imm12[11]}}, ins.i.imm12};
                if (ins.i.funct3 == F3_SLL) legal = (ins.r.funct7 == F7_BASE);
                else if (ins.i.funct3 == F3_SR) legal = alt || (ins.r.funct7 == F7_BASE);
                else legal = 1'b1;
                res = alu_ref(ins.i.funct3, alt && (ins.i.funct3 == F3_SR), a, b);  // No subi
            end
            OPC_LUI: begin
                legal = 1'b1;
                res   = {word[31:12], 12'b0};
            end
            default: ;
        endcase
        if (legal && ins.r.rd != 5'd0) begin
            mregs[ins.r.rd] = res;
        end
        exp_rd_q.push_back(ins.r.rd);
        exp_data_q.push_back(res);
        exp_ill_q.push_back(!legal);
        stamp_q.push_back(adv_cnt);
    endtask

    function automatic logic [31:0] rand_instr();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        r   = $random(seed);
        rd  = {2'b00, r[2:0]};  // Eight registers keep hazards frequent
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3  = r[11:9];
        case (r[14:12])
            3'd0, 3'd1: begin
                if ((f3 == F3_ADD || f3 == F3_SR) && r[15]) return enc_r(F7_ALT, rs2, rs1, f3, rd);
                return enc_r(F7_BASE, rs2, rs1, f3, rd);
            end
            3'd2, 3'd3: begin
                if (f3 == F3_SLL) return enc_i({F7_BASE, r[20:16]}, rs1, f3, rd);
                if (f3 == F3_SR) return enc_i({r[15] ? F7_ALT : F7_BASE, r[20:16]}, rs1, f3, rd);
                return enc_i(r[27:16], rs1, f3, rd);
            end
            3'd4:    return enc_u(r[31:12], rd);
            3'd5:    return enc_r(7'h01, rs2, rs1, f3, rd);  // M extension
            3'd6:    return {r[31:7], 7'b0001011};          // custom-0 opcode
            default: return enc_i(r[27:16], rs1, f3, 5'd0);
        endcase
    endfunction

    task automatic send_instr(input logic [31:0] word);
        int waited;
        waited = 0;
        instr_valid_i <= 1'b1;
        instr_data_i  <= word;
        @(negedge clk_i);
        while (!instr_ready_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        if (!instr_ready_o) report_error("instruction handshake timed out");
        @(posedge clk_i);
    endtask

    task automatic idle_cycle();
        instr_valid_i <= 1'b0;
        @(posedge clk_i);
    endtask

    task automatic drive_ready();
        forever begin
            @(posedge clk_i);
            result_ready_i <= rand_ready ? ready_pat[ready_idx % 1024] : 1'b1;
            ready_idx++;
        end
    endtask

    // Sample at the falling edge, where every DUT output is settled
    always @(negedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                mregs[i] = '0;
            end
            adv_cnt    = 0;
            stall_prev = 1'b0;
        end else begin
            if (instr_valid_i && instr_ready_o) begin
                model_accept(instr_data_i);
            end
            if (stall_prev) begin  // Held item must not move
                assert (result_valid_o) else report_error("result_valid_o dropped while stalled");
                assert (result_rd_o == last_rd)
                    else value_mismatch("result_rd_o", 32'(result_rd_o), 32'(last_rd));
                assert (result_data_o == last_data)
                    else value_mismatch("result_data_o", result_data_o, last_data);
                assert (result_illegal_o == last_ill)
                    else value_mismatch("result_illegal_o", 32'(result_illegal_o), 32'(last_ill));
            end
            if (result_valid_o && result_ready_i) begin
                assert (exp_rd_q.size() != 0) else report_error("result with nothing outstanding");
                assert (result_rd_o == exp_rd_q[0])
                    else value_mismatch("result_rd_o", 32'(result_rd_o), 32'(exp_rd_q[0]));
                assert (result_illegal_o == exp_ill_q[0])
                    else value_mismatch("result_illegal_o", 32'(result_illegal_o),
                                        32'(exp_ill_q[0]));
                if (!exp_ill_q[0]) begin
                    assert (result_data_o == exp_data_q[0])
                        else value_mismatch("result_data_o", result_data_o, exp_data_q[0]);
                end
                // Three advancing edges from acceptance to transfer
                assert (adv_cnt - stamp_q[0] == 3)
                    else value_mismatch("result latency", 32'(adv_cnt - stamp_q[0]), 32'd3);
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_ill_q.pop_front());
                void'(stamp_q.pop_front());
            end
            stall_prev = result_valid_o && !result_ready_i;
            last_rd    = result_rd_o;
            last_data  = result_data_o;
            last_ill   = result_illegal_o;
            if (!stall_prev) adv_cnt++;
        end
    end

    initial begin
        int          waited;
        logic [31:0] r;
        seed           = 25;
        ready_idx      = 0;
        rst_ni         <= 1'b0;
        instr_valid_i  <= 1'b0;
        instr_data_i   <= '0;
        result_ready_i <= 1'b1;
        rand_ready     <= 1'b0;
        for (int i = 0; i < 1024; i++) begin
            r            = $random(seed);
            ready_pat[i] = r[0];
        end
        fork
            drive_ready();
        join_none
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        assert (!result_valid_o) else value_mismatch("result_valid_o", 32'(result_valid_o), 32'd0);
        assert (instr_ready_o) else value_mismatch("instr_ready_o", 32'(instr_ready_o), 32'd1);
        @(posedge clk_i);

        // Dependent chain through both forwarding paths
        send_instr(enc_i(12'd5, 5'd0, F3_ADD, 5'd1));
        send_instr(enc_i(12'hffd, 5'd0, F3_ADD, 5'd2));
        send_instr(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd3));
        send_instr(enc_r(F7_ALT, 5'd1, 5'd3, F3_ADD, 5'd4));
        send_instr(enc_r(F7_BASE, 5'd3, 5'd4, F3_XOR, 5'd5));
        send_instr(enc_r(F7_BASE, 5'd2, 5'd5, F3_SLT, 5'd6));
        send_instr(enc_r(F7_BASE, 5'd2, 5'd5, F3_SLTU, 5'd7));
        send_instr(enc_r(F7_BASE, 5'd1, 5'd2, F3_SLL, 5'd1));
        send_instr(enc_r(F7_BASE, 5'd3, 5'd1, F3_SR, 5'd6));
        send_instr(enc_r(F7_ALT, 5'd3, 5'd1, F3_SR, 5'd7));
        send_instr(enc_r(F7_BASE, 5'd7, 5'd6, F3_OR, 5'd3));
        send_instr(enc_r(F7_BASE, 5'd3, 5'd2, F3_AND, 5'd4));
        // Negative immediates, shifts and lui
        send_instr(enc_i(12'hf9c, 5'd4, F3_ADD, 5'd1));  // -100
        send_instr(enc_i(12'hfff, 5'd1, F3_SLT, 5'd2));
        send_instr(enc_i(12'hfff, 5'd1, F3_SLTU, 5'd3));
        send_instr(enc_i(12'h800, 5'd1, F3_XOR, 5'd4));
        send_instr(enc_i(12'h0f0, 5'd1, F3_OR, 5'd5));
        send_instr(enc_i(12'h8ff, 5'd5, F3_AND, 5'd6));
        send_instr(enc_i(12'h01f, 5'd1, F3_SLL, 5'd7));
        send_instr(enc_i(12'h007, 5'd1, F3_SR, 5'd2));
        send_instr(enc_i(12'h404, 5'd1, F3_SR, 5'd3));  // srai by 4
        send_instr(enc_u(20'habcde, 5'd4));
        send_instr(enc_r(F7_BASE, 5'd3, 5'd4, F3_ADD, 5'd5));
        // x0 written, then read right away
        send_instr(enc_i(12'd7, 5'd5, F3_ADD, 5'd0));
        send_instr(enc_r(F7_BASE, 5'd0, 5'd5, F3_ADD, 5'd6));
        // Unsupported encodings, then reads of their destinations
        send_instr({20'habcde, 5'd5, 7'b0001011});
        send_instr(enc_r(7'h01, 5'd5, 5'd5, F3_ADD, 5'd6));
        send_instr(enc_i(12'h405, 5'd5, F3_SLL, 5'd7));
        send_instr(enc_r(F7_ALT, 5'd6, 5'd5, F3_XOR, 5'd7));
        send_instr(enc_r(F7_BASE, 5'd6, 5'd5, F3_OR, 5'd1));
        send_instr(enc_r(F7_BASE, 5'd0, 5'd7, F3_ADD, 5'd2));
        idle_cycle();

        // Random mix under random back-pressure
        rand_ready <= 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) idle_cycle();
            send_instr(rand_instr());
        end
        idle_cycle();
        rand_ready <= 1'b0;

        waited = 0;
        while (exp_rd_q.size() != 0 && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk_i);
        end
        if (exp_rd_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_error("results still outstanding after the drain timeout");
        end
    end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  instr_valid_i,
    input  logic [XLEN-1:0]       instr_data_i,
    input  logic                  pipe_advance_i,
    output logic                  instr_ready_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  logic                  fwd_ex_valid_i,
    input  logic [REG_ADDR_W-1:0] fwd_ex_rd_i,
    input  logic                  fwd_ex_wen_i,
    input  logic [XLEN-1:0]       fwd_ex_data_i,
    input  logic                  fwd_wb_valid_i,
    input  logic [REG_ADDR_W-1:0] fwd_wb_rd_i,
    input  logic                  fwd_wb_wen_i,
    input  logic [XLEN-1:0]       fwd_wb_data_i,
    output logic                  ex_valid_o,
    output logic [ALU_OP_W-1:0]   ex_alu_op_o,
    output logic [XLEN-1:0]       ex_opa_o,
    output logic [XLEN-1:0]       ex_opb_o,
    output logic [REG_ADDR_W-1:0] ex_rd_o,
    output logic                  ex_wen_o,
    output logic                  ex_illegal_o
);

    logic                dec_valid_q;
    rv_instr_t           instr_q;
    logic                legal;
    logic                use_imm;
    logic                alt;
    logic [ALU_OP_W-1:0] alu_op;
    logic [XLEN-1:0]     imm;
    logic [XLEN-1:0]     rs1_fwd;
    logic [XLEN-1:0]     rs2_fwd;

    function automatic logic [ALU_OP_W-1:0] f3_to_alu_op(input logic [2:0] f3, input logic alt_i);
        logic [ALU_OP_W-1:0] op;
        case (f3)
            F3_ADD:  op = alt_i ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt_i ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign instr_ready_o = pipe_advance_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dec_valid_q <= 1'b0;
        end else if (pipe_advance_i) begin
            dec_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pipe_advance_i) instr_q <= instr_data_i;
    end

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b0;
        alt     = 1'b0;
        imm     = '0;
        alu_op  = ALU_PASS_B;
        case (instr_q.r.opcode)
            OPC_OP: begin
                alt    = (instr_q.r.funct7 == F7_ALT);
                legal  = (instr_q.r.funct7 == F7_BASE) ||
                         (alt && (instr_q.r.funct3 == F3_ADD || instr_q.r.funct3 == F3_SR));
                alu_op = f3_to_alu_op(instr_q.r.funct3, alt);
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                imm     = {{(XLEN-12){instr_q.i.imm12[11]}}, instr_q.i.imm12};
                if (instr_q.i.funct3 == F3_SLL) begin
                    legal = (instr_q.r.funct7 == F7_BASE);
                end else if (instr_q.i.funct3 == F3_SR) begin
                    alt   = (instr_q.r.funct7 == F7_ALT);  // srai
                    legal = alt || (instr_q.r.funct7 == F7_BASE);
                end else begin
                    legal = 1'b1;
                end
                alu_op = f3_to_alu_op(instr_q.i.funct3, alt);
            end
            OPC_LUI: begin
                use_imm = 1'b1;
                imm     = {instr_q.r.funct7, instr_q.r.rs2, instr_q.r.rs1,
                           instr_q.r.funct3, 12'b0};
                legal   = 1'b1;
            end
            default: ;  // Illegal, flows through as a zero result
        endcase
        if (!legal) alu_op = ALU_PASS_B;
    end

    assign rs1_addr_o = instr_q.r.rs1;
    assign rs2_addr_o = instr_q.r.rs2;

    // Nearest older writer wins, x0 never forwarded
    assign rs1_fwd =
        (rs1_addr_o == '0) ? '0 :
        (fwd_ex_valid_i && fwd_ex_wen_i && fwd_ex_rd_i == rs1_addr_o) ? fwd_ex_data_i :
        (fwd_wb_valid_i && fwd_wb_wen_i && fwd_wb_rd_i == rs1_addr_o) ? fwd_wb_data_i :
        rs1_data_i;
    assign rs2_fwd =
        (rs2_addr_o == '0) ? '0 :
        (fwd_ex_valid_i && fwd_ex_wen_i && fwd_ex_rd_i == rs2_addr_o) ? fwd_ex_data_i :
        (fwd_wb_valid_i && fwd_wb_wen_i && fwd_wb_rd_i == rs2_addr_o) ? fwd_wb_data_i :
        rs2_data_i;

    assign ex_valid_o   = dec_valid_q;
    assign ex_alu_op_o  = alu_op;
    assign ex_opa_o     = rs1_fwd;
    assign ex_opb_o     = !legal ? '0 : (use_imm ? imm : rs2_fwd);
    assign ex_rd_o      = instr_q.r.rd;
    assign ex_wen_o     = legal && (instr_q.r.rd != '0);
    assign ex_illegal_o = !legal;

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import pipe_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  pipe_advance_i,
    input  logic                  ex_valid_i,
    input  logic [ALU_OP_W-1:0]   ex_alu_op_i,
    input  logic [XLEN-1:0]       ex_opa_i,
    input  logic [XLEN-1:0]       ex_opb_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_i,
    input  logic                  ex_wen_i,
    input  logic                  ex_illegal_i,
    output logic                  res_valid_o,
    output logic [REG_ADDR_W-1:0] res_rd_o,
    output logic [XLEN-1:0]       res_data_o,
    output logic                  res_wen_o,
    output logic                  res_illegal_o
);

    logic                  valid_q;
    logic [ALU_OP_W-1:0]   alu_op_q;
    logic [XLEN-1:0]       opa_q;
    logic [XLEN-1:0]       opb_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic                  wen_q;
    logic                  illegal_q;
    logic [4:0]            shamt;
    logic [XLEN-1:0]       alu_data;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (pipe_advance_i) begin
            valid_q <= ex_valid_i;
        end
    end

    // Operation and operands, qualified by valid_q
    always_ff @(posedge clk_i) begin
        if (pipe_advance_i) begin
            alu_op_q  <= ex_alu_op_i;
            opa_q     <= ex_opa_i;
            opb_q     <= ex_opb_i;
            rd_q      <= ex_rd_i;
            wen_q     <= ex_wen_i;
            illegal_q <= ex_illegal_i;
        end
    end

    assign shamt = opb_q[4:0];

    always_comb begin
        case (alu_op_q)
            ALU_ADD:    alu_data = opa_q + opb_q;
            ALU_SUB:    alu_data = opa_q - opb_q;
            ALU_SLL:    alu_data = opa_q << shamt;
            ALU_SLT:    alu_data = {{(XLEN-1){1'b0}}, $signed(opa_q) < $signed(opb_q)};
            ALU_SLTU:   alu_data = {{(XLEN-1){1'b0}}, opa_q < opb_q};
            ALU_XOR:    alu_data = opa_q ^ opb_q;
            ALU_SRL:    alu_data = opa_q >> shamt;
            ALU_SRA:    alu_data = $unsigned($signed(opa_q) >>> shamt);  // Sign fill
            ALU_OR:     alu_data = opa_q | opb_q;
            ALU_AND:    alu_data = opa_q & opb_q;
            ALU_PASS_B: alu_data = opb_q;
            default:    alu_data = '0;
        endcase
    end

    assign res_valid_o   = valid_q;
    assign res_rd_o      = rd_q;
    assign res_data_o    = alu_data;
    assign res_wen_o     = wen_q;
    assign res_illegal_o = illegal_q;

endmodule

`default_nettype wire

//--- source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    localparam int XLEN       = 32;  // Data width
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int ALU_OP_W   = 4;

    // ALU operation codes
    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;  // lui and illegal slots

endpackage

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import pipe_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    // x0 has no storage
    logic [XLEN-1:0] regs_q [NUM_REGS-1:1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous reads, address zero reads zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

//--- source/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage import pipe_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  result_ready_i,
    input  logic                  res_valid_i,
    input  logic [REG_ADDR_W-1:0] res_rd_i,
    input  logic [XLEN-1:0]       res_data_i,
    input  logic                  res_wen_i,
    input  logic                  res_illegal_i,
    output logic                  pipe_advance_o,
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic                  wb_wen_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic                  result_valid_o,
    output logic [REG_ADDR_W-1:0] result_rd_o,
    output logic [XLEN-1:0]       result_data_o,
    output logic                  result_illegal_o
);

    logic                  valid_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [XLEN-1:0]       data_q;
    logic                  wen_q;
    logic                  illegal_q;

    // Whole pipe moves when this slot drains or is empty
    assign pipe_advance_o = !valid_q || result_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (pipe_advance_o) begin
            valid_q <= res_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pipe_advance_o) begin
            rd_q      <= res_rd_i;
            data_q    <= res_data_i;
            wen_q     <= res_wen_i;
            illegal_q <= res_illegal_i;
        end
    end

    assign wb_valid_o = valid_q;
    assign wb_rd_o    = rd_q;
    assign wb_data_o  = data_q;
    assign wb_wen_o   = valid_q && result_ready_i && wen_q;  // Transfer edge only, wen implies legal

    assign result_valid_o   = valid_q;
    assign result_rd_o      = rd_q;
    assign result_data_o    = data_q;
    assign result_illegal_o = illegal_q;

endmodule

`default_nettype wire

//--- source/rv_alu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu_pipe import pipe_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  instr_valid_i,
    input  logic [XLEN-1:0]       instr_data_i,
    output logic                  instr_ready_o,
    input  logic                  result_ready_i,
    output logic                  result_valid_o,
    output logic [REG_ADDR_W-1:0] result_rd_o,
    output logic [XLEN-1:0]       result_data_o,
    output logic                  result_illegal_o
);

    logic                  pipe_advance;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data;
    // Decode to execute
    logic                  ex_valid, ex_wen, ex_illegal;
    logic [ALU_OP_W-1:0]   ex_alu_op;
    logic [XLEN-1:0]       ex_opa, ex_opb;
    logic [REG_ADDR_W-1:0] ex_rd;
    // Execute to result, also forwarded
    logic                  res_valid, res_wen, res_illegal;
    logic [REG_ADDR_W-1:0] res_rd;
    logic [XLEN-1:0]       res_data;
    // Write-back, also forwarded
    logic                  wb_valid, wb_wen;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    decode_stage u_decode_stage (
        .clk_i, .rst_ni, .instr_valid_i, .instr_data_i, .instr_ready_o,
        .pipe_advance_i (pipe_advance),
        .rs1_data_i     (rs1_data),    .rs2_data_i     (rs2_data),
        .rs1_addr_o     (rs1_addr),    .rs2_addr_o     (rs2_addr),
        .fwd_ex_valid_i (res_valid),   .fwd_ex_rd_i    (res_rd),
        .fwd_ex_wen_i   (res_wen),     .fwd_ex_data_i  (res_data),
        .fwd_wb_valid_i (wb_valid),    .fwd_wb_rd_i    (wb_rd),
        .fwd_wb_wen_i   (wb_wen),      .fwd_wb_data_i  (wb_data),
        .ex_valid_o     (ex_valid),    .ex_alu_op_o    (ex_alu_op),
        .ex_opa_o       (ex_opa),      .ex_opb_o       (ex_opb),
        .ex_rd_o        (ex_rd),       .ex_wen_o       (ex_wen),
        .ex_illegal_o   (ex_illegal)
    );

    execute_stage u_execute_stage (
        .clk_i, .rst_ni,
        .pipe_advance_i (pipe_advance),
        .ex_valid_i     (ex_valid),    .ex_alu_op_i    (ex_alu_op),
        .ex_opa_i       (ex_opa),      .ex_opb_i       (ex_opb),
        .ex_rd_i        (ex_rd),       .ex_wen_i       (ex_wen),
        .ex_illegal_i   (ex_illegal),
        .res_valid_o    (res_valid),   .res_rd_o       (res_rd),
        .res_data_o     (res_data),    .res_wen_o      (res_wen),
        .res_illegal_o  (res_illegal)
    );

    result_stage u_result_stage (
        .clk_i, .rst_ni, .result_ready_i,
        .res_valid_i    (res_valid),   .res_rd_i       (res_rd),
        .res_data_i     (res_data),    .res_wen_i      (res_wen),
        .res_illegal_i  (res_illegal),
        .pipe_advance_o (pipe_advance),
        .wb_valid_o     (wb_valid),    .wb_rd_o        (wb_rd),
        .wb_wen_o       (wb_wen),      .wb_data_o      (wb_data),
        .result_valid_o, .result_rd_o, .result_data_o, .result_illegal_o
    );

    reg_file u_reg_file (
        .clk_i, .rst_ni,
        .we_i     (wb_wen),   .waddr_i  (wb_rd),    .wdata_i  (wb_data),
        .raddr1_i (rs1_addr), .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data), .rdata2_o (rs2_data)
    );

endmodule

`default_nettype wire

//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl and sra share it
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct7
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // Selects sub and sra

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_type_t;

    // Register-immediate layout
    typedef struct packed {
        logic [11:0] imm12;  // Shift amount sits in the low five bits
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_type_t;

    // One instruction word, two views of the same bits
    // The lui immediate spans funct7 down to funct3 of the R view
    typedef union packed {
        rv_r_type_t r;
        rv_i_type_t i;
    } rv_instr_t;

endpackage

`default_nettype wire
